//--- bundle_buffer/bundle_buffer.sv
`default_nettype none

module bundle_buffer import hdc_pkg::*; #(
    // hypervector width
    parameter int DIM       = DEFAULT_DIM,
    // number of binding cores feeding the buffer
    parameter int NUM_CORES = DEFAULT_NUM_CORES
) (
    input  wire logic                     clk,
    input  wire logic                     arst_n,
    // clear all counters
    input  wire logic                     clear,
    // per-core store strobes
    input  wire logic [NUM_CORES-1:0]     store,
    // flat bound vectors with core k in slice k
    input  wire logic [NUM_CORES*DIM-1:0] core_results,
    // read strobe
    input  wire logic                     read_v,
    // captured bundled vector
    output logic      [DIM-1:0]           stream_d,
    output logic                          stream_valid,
    // live majority vector
    output logic      [DIM-1:0]           sign_bit
);

    // bits regrouped per dimension with one bit per core
    logic [NUM_CORES-1:0] dim_results [DIM];

    // regroup and one counter per dimension
    for (genvar i = 0; i < DIM; i++) begin : g_dim

        // core order kept with core 0 at bit 0
        for (genvar k = 0; k < NUM_CORES; k++) begin : g_core
            assign dim_results[i][k] = core_results[k*DIM + i];
        end

        dim_counter #(
            .NUM_CORES   (NUM_CORES)
        ) u_dim_counter (
            .clk         (clk),
            .arst_n      (arst_n),
            .clear       (clear),
            .store       (store),
            .core_result (dim_results[i]),
            .sign_bit    (sign_bit[i])
        );

    end

    // stream capture
    // samples the sign vector from before the edge
    // so a store landing on the same edge is not seen
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stream_d <= '0;
        end else if (read_v) begin
            stream_d <= sign_bit;
        end
    end

    // valid flag one cycle after the strobe
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stream_valid <= 1'b0;
        end else begin
            stream_valid <= read_v;
        end
    end

    // a clear empties every counter
    // so the whole majority vector drops to zero
    a_clear_zeroes_signs : assert property (
        @(posedge clk) disable iff (!arst_n)
        $past(clear) |-> (sign_bit == '0)
    ) else $error("bundle_buffer: sign vector not zero after clear");

endmodule

`default_nettype wire

//--- bundle_buffer/dim_counter.sv
`default_nettype none

module dim_counter import hdc_pkg::*; #(
    // number of voting cores
    parameter int NUM_CORES = DEFAULT_NUM_CORES
) (
    input  wire logic                 clk,
    input  wire logic                 arst_n,
    // clear strobe, beats any store in the same cycle
    input  wire logic                 clear,
    // per-core vote enable
    input  wire logic [NUM_CORES-1:0] store,
    // this dimension's bit from every core, core 0 at lsb
    input  wire logic [NUM_CORES-1:0] core_result,
    // majority sign, 1 only for a strictly positive count
    output logic                      sign_bit
);

    // room for the count plus NUM_CORES votes of either sign
    localparam int SUM_W = CNT_W + $clog2(NUM_CORES + 1) + 1;

    cnt_t                    cnt;
    cnt_t                    next_cnt;
    logic signed [SUM_W-1:0] sum;

    // unsaturated sum of current count and all enabled votes
    always_comb begin
        sum = SUM_W'(cnt);
        for (int k = 0; k < NUM_CORES; k++) begin
            if (store[k]) begin
                // bit 1 votes up, bit 0 votes down
                if (core_result[k]) begin
                    sum = sum + 1;
                end else begin
                    sum = sum - 1;
                end
            end
        end
    end

    // clamp into cnt_t range
    always_comb begin
        if (sum > CNT_MAX) begin
            next_cnt = cnt_t'(CNT_MAX);
        end else if (sum < CNT_MIN) begin
            next_cnt = cnt_t'(CNT_MIN);
        end else begin
            next_cnt = cnt_t'(sum);
        end
    end

    // count register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt <= '0;
        end else if (clear) begin
            // a store in this cycle is dropped
            cnt <= '0;
        end else if (|store) begin
            cnt <= next_cnt;
        end
    end

    // positive and nonzero, a tie gives 0
    assign sign_bit = !cnt[CNT_W-1] && (cnt != '0);

    // count stays in bounds and never jumps further than one round of votes
    // a jump would mean the saturation logic let the counter wrap
    a_cnt_no_wrap : assert property (
        @(posedge clk) disable iff (!arst_n)
        !$past(clear) |->
            (int'(cnt) >= CNT_MIN) && (int'(cnt) <= CNT_MAX) &&
            (int'(cnt) - int'($past(cnt)) <= NUM_CORES) &&
            (int'($past(cnt)) - int'(cnt) <= NUM_CORES)
    ) else $error("dim_counter: count left its range or wrapped");

endmodule

`default_nettype wire

//--- common/hdc_pkg.sv
`default_nettype none

package hdc_pkg;

    // per-dimension vote counter width
    // fixed, the saturation bounds below are derived from it
    localparam int CNT_W = 8;

    // one dimension's running vote total, two's complement
    typedef logic signed [CNT_W-1:0] cnt_t;

    // saturation bounds of cnt_t
    // +127 on the positive side
    localparam int CNT_MAX = (1 << (CNT_W - 1)) - 1;
    // -128 on the negative side
    localparam int CNT_MIN = -(1 << (CNT_W - 1));

    // default hypervector width in bits
    localparam int DEFAULT_DIM = 64;

    // default number of parallel binding cores
    localparam int DEFAULT_NUM_CORES = 4;

endpackage

`default_nettype wire

//--- list.f
common/hdc_pkg.sv
rtl/bind_core.sv
bundle_buffer/dim_counter.sv
bundle_buffer/bundle_buffer.sv
rtl/hdc_bundler_top.sv
test/tb_hdc_bundler.sv

//--- rtl/bind_core.sv
`default_nettype none

module bind_core import hdc_pkg::*; #(
    // hypervector width
    parameter int DIM   = DEFAULT_DIM,
    // left rotation applied after the key xor
    parameter int SHIFT = 0
) (
    input  wire logic           clk,
    input  wire logic           arst_n,
    // single-cycle sample strobe
    input  wire logic           sample_valid,
    // core enable sampled with the strobe
    input  wire logic           enable,
    input  wire logic [DIM-1:0] sample_hv,
    input  wire logic [DIM-1:0] key_hv,
    output logic      [DIM-1:0] bound_hv,
    // one-cycle vote strobe towards the buffer
    output logic                store
);

    // effective rotation
    // shifts past DIM wrap around
    localparam int ROT = SHIFT % DIM;

    logic [DIM-1:0] mixed;
    logic [DIM-1:0] rotated;

    // binding by key
    assign mixed = sample_hv ^ key_hv;

    // permutation moves bit i up by ROT
    always_comb begin
        for (int i = 0; i < DIM; i++) begin
            rotated[(i + ROT) % DIM] = mixed[i];
        end
    end

    // bound vector register
    // only loaded on a sample
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bound_hv <= '0;
        end else if (sample_valid) begin
            bound_hv <= rotated;
        end
    end

    // store pulses one cycle after an enabled sample
    // lines up with bound_hv
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            store <= 1'b0;
        end else begin
            store <= sample_valid & enable;
        end
    end

    // a vote never carries unknown bits into the buffer
    a_store_known_data : assert property (
        @(posedge clk) disable iff (!arst_n)
        store |-> !$isunknown(bound_hv)
    ) else $error("bind_core: store with unknown bound vector");

endmodule

`default_nettype wire

//--- rtl/hdc_bundler_top.sv
`default_nettype none

module hdc_bundler_top import hdc_pkg::*; #(
    // hypervector width
    parameter int DIM       = DEFAULT_DIM,
    // number of parallel binding cores
    parameter int NUM_CORES = DEFAULT_NUM_CORES
) (
    input  wire logic                     clk,
    input  wire logic                     arst_n,
    // sample strobe for all cores
    input  wire logic                     sample_valid,
    // flat input vectors, core k in slice k
    input  wire logic [NUM_CORES*DIM-1:0] sample_hv,
    // flat key vectors, core k in slice k
    input  wire logic [NUM_CORES*DIM-1:0] key_hv,
    // per-core enable mask
    input  wire logic [NUM_CORES-1:0]     core_en,
    // clear strobe for the counters
    input  wire logic                     clear,
    // read strobe for the stream register
    input  wire logic                     read_v,
    output logic      [DIM-1:0]           stream_d,
    output logic                          stream_valid,
    // live majority vector
    output logic      [DIM-1:0]           sign_bit
);

    // bound vectors from all cores, same slicing as the inputs
    logic [NUM_CORES*DIM-1:0] bound_bus;
    // per-core vote strobes
    logic [NUM_CORES-1:0]     store_vec;

    // binding cores
    // rotation equals core index to decorrelate the cores
    for (genvar k = 0; k < NUM_CORES; k++) begin : g_core
        bind_core #(
            .DIM          (DIM),
            .SHIFT        (k)
        ) u_bind_core (
            .clk          (clk),
            .arst_n       (arst_n),
            .sample_valid (sample_valid),
            .enable       (core_en[k]),
            .sample_hv    (sample_hv[k*DIM +: DIM]),
            .key_hv       (key_hv[k*DIM +: DIM]),
            .bound_hv     (bound_bus[k*DIM +: DIM]),
            .store        (store_vec[k])
        );
    end

    // counters, majority and stream capture
    bundle_buffer #(
        .DIM          (DIM),
        .NUM_CORES    (NUM_CORES)
    ) u_bundle_buffer (
        .clk          (clk),
        .arst_n       (arst_n),
        .clear        (clear),
        .store        (store_vec),
        .core_results (bound_bus),
        .read_v       (read_v),
        .stream_d     (stream_d),
        .stream_valid (stream_valid),
        .sign_bit     (sign_bit)
    );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run the hdc bundler testbench with verilator
# a build or run error also counts as a failed run

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module tb_hdc_bundler -o tb_sim -f list.f > sim.log 2>&1 \
    && ./obj_dir/tb_sim >> sim.log 2>&1 \
    || echo "Checks failed" >> sim.log

cat sim.log

grep -q "Checks failed" sim.log && echo "simulation FAILED" && exit 1
echo "simulation passed"
exit 0

//--- test/tb_hdc_bundler.sv
`default_nettype none

module tb_hdc_bundler import hdc_pkg::*;;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int DIM          = 64;
    localparam int NUM_CORES    = 4;
    localparam int HALF_PERIOD  = 20;
    localparam int DRIVE_DELAY  = 2;
    localparam int RESET_CYCLES = 5;

    // row operations, bits may be combined
    localparam logic [2:0] OP_IDLE   = 3'b000;
    localparam logic [2:0] OP_SAMPLE = 3'b001;
    localparam logic [2:0] OP_CLEAR  = 3'b010;
    localparam logic [2:0] OP_READ   = 3'b100;

    // fresh random sample per core
    localparam logic [1:0] PAT_RAND  = 2'd0;
    // sample is the inverted key, every bound bit becomes 1
    localparam logic [1:0] PAT_ONES  = 2'd1;
    // sample equals the key, every bound bit becomes 0
    localparam logic [1:0] PAT_ZEROS = 2'd2;

    // one table row, applied repeat_n cycles in a row
    typedef struct packed {
        logic [3:0]           test_id;
        logic [2:0]           op;
        logic [NUM_CORES-1:0] en;
        logic [1:0]           pat;
        logic [7:0]           repeat_n;
    } row_t;

    // dut inputs
    logic                     clk;
    logic                     arst_n;
    logic                     sample_valid;
    logic [NUM_CORES*DIM-1:0] sample_hv;
    logic [NUM_CORES*DIM-1:0] key_hv;
    logic [NUM_CORES-1:0]     core_en;
    logic                     clear;
    logic                     read_v;

    // dut outputs
    logic [DIM-1:0]           stream_d;
    logic                     stream_valid;
    logic [DIM-1:0]           sign_bit;

    // stimulus table
    row_t rows[$];

    // reference model state
    int                       m_cnt [DIM];
    logic [DIM-1:0]           m_bound [NUM_CORES];
    logic [NUM_CORES-1:0]     m_store;
    logic [DIM-1:0]           m_stream_d;
    logic                     m_stream_valid;

    // bookkeeping
    integer     seed;
    int         cycles = 0;
    int         limit = 0;
    int         n_checks = 0;
    int         n_errors = 0;
    int         test_errors = 0;
    logic [3:0] cur_test;

    hdc_bundler_top #(
        .DIM          (DIM),
        .NUM_CORES    (NUM_CORES)
    ) u_dut (
        .clk          (clk),
        .arst_n       (arst_n),
        .sample_valid (sample_valid),
        .sample_hv    (sample_hv),
        .key_hv       (key_hv),
        .core_en      (core_en),
        .clear        (clear),
        .read_v       (read_v),
        .stream_d     (stream_d),
        .stream_valid (stream_valid),
        .sign_bit     (sign_bit)
    );

    // free-running clock, 40 ns period
    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    task automatic add_row(input int test, input logic [2:0] op,
                           input logic [NUM_CORES-1:0] en, input logic [1:0] pat,
                           input int rep);
        row_t row;
        row.test_id  = 4'(test);
        row.op       = op;
        row.en       = en;
        row.pat      = pat;
        row.repeat_n = 8'(rep);
        rows.push_back(row);
    endtask

    task automatic build_table();
        // 1: reset state, first reads see zeros
        add_row(1, OP_IDLE,   4'h0, PAT_RAND,  3);
        add_row(1, OP_READ,   4'h0, PAT_RAND,  1);
        add_row(1, OP_IDLE,   4'h0, PAT_RAND,  1);
        add_row(1, OP_READ,   4'h0, PAT_RAND,  1);
        add_row(1, OP_IDLE,   4'h0, PAT_RAND,  2);
        // 2: one sample from all four cores
        add_row(2, OP_SAMPLE, 4'hf, PAT_RAND,  1);
        add_row(2, OP_IDLE,   4'h0, PAT_RAND,  1);
        add_row(2, OP_READ,   4'h0, PAT_RAND,  1);
        add_row(2, OP_IDLE,   4'h0, PAT_RAND,  1);
        // 3: partial enable masks, an all-off mask votes nothing
        add_row(3, OP_CLEAR,  4'h0, PAT_RAND,  1);
        add_row(3, OP_SAMPLE, 4'h5, PAT_RAND,  1);
        add_row(3, OP_IDLE,   4'h0, PAT_RAND,  1);
        add_row(3, OP_SAMPLE, 4'h8, PAT_RAND,  1);
        add_row(3, OP_SAMPLE, 4'h0, PAT_ONES,  1);
        add_row(3, OP_IDLE,   4'h0, PAT_RAND,  1);
        add_row(3, OP_READ,   4'h0, PAT_RAND,  1);
        add_row(3, OP_IDLE,   4'h0, PAT_RAND,  1);
        // 4: clear lands on the store cycle and wins
        add_row(4, OP_CLEAR,  4'h0, PAT_RAND,  1);
        add_row(4, OP_IDLE,   4'h0, PAT_RAND,  1);
        add_row(4, OP_SAMPLE, 4'hf, PAT_ONES,  1);
        add_row(4, OP_CLEAR,  4'h0, PAT_RAND,  1);
        add_row(4, OP_READ,   4'h0, PAT_RAND,  1);
        add_row(4, OP_IDLE,   4'h0, PAT_RAND,  1);
        // 5: saturate high, one opposite vote, then saturate low
        add_row(5, OP_CLEAR,  4'h0, PAT_RAND,  1);
        add_row(5, OP_SAMPLE, 4'hf, PAT_ONES,  140);
        add_row(5, OP_IDLE,   4'h0, PAT_RAND,  1);
        add_row(5, OP_READ,   4'h0, PAT_RAND,  1);
        add_row(5, OP_SAMPLE, 4'hf, PAT_ZEROS, 1);
        add_row(5, OP_IDLE,   4'h0, PAT_RAND,  1);
        add_row(5, OP_READ,   4'h0, PAT_RAND,  1);
        add_row(5, OP_SAMPLE, 4'hf, PAT_ZEROS, 140);
        add_row(5, OP_IDLE,   4'h0, PAT_RAND,  1);
        add_row(5, OP_SAMPLE, 4'hf, PAT_ONES,  1);
        add_row(5, OP_IDLE,   4'h0, PAT_RAND,  1);
        add_row(5, OP_READ,   4'h0, PAT_RAND,  1);
        add_row(5, OP_IDLE,   4'h0, PAT_RAND,  1);
        // 6: reads overlapping stores
        add_row(6, OP_CLEAR,  4'h0, PAT_RAND,  1);
        add_row(6, OP_IDLE,   4'h0, PAT_RAND,  1);
        add_row(6, OP_SAMPLE, 4'hf, PAT_RAND,  1);
        add_row(6, OP_READ,   4'h0, PAT_RAND,  1);
        add_row(6, OP_READ,   4'h0, PAT_RAND,  1);
        add_row(6, OP_IDLE,   4'h0, PAT_RAND,  1);
        add_row(6, OP_SAMPLE | OP_READ, 4'h7, PAT_RAND, 1);
        add_row(6, OP_READ,   4'h0, PAT_RAND,  1);
        add_row(6, OP_IDLE,   4'h0, PAT_RAND,  2);
    endtask

    function automatic int table_cycles();
        int total;
        total = 0;
        for (int r = 0; r < rows.size(); r++) begin
            total += int'(rows[r].repeat_n);
        end
        return total;
    endfunction

    function automatic string test_name(input logic [3:0] id);
        case (id)
            4'd1:    return "reset state";
            4'd2:    return "single sample majority";
            4'd3:    return "core enable mask";
            4'd4:    return "clear beats store";
            4'd5:    return "counter saturation";
            4'd6:    return "read during store";
            default: return "unknown";
        endcase
    endfunction

    // left rotation by s places
    function automatic logic [DIM-1:0] rotl(input logic [DIM-1:0] x, input int s);
        if (s == 0) begin
            return x;
        end
        return (x << s) | (x >> (DIM - s));
    endfunction

    // majority sign, strictly positive count gives 1
    function automatic logic [DIM-1:0] model_sign();
        logic [DIM-1:0] s;
        for (int i = 0; i < DIM; i++) begin
            s[i] = (m_cnt[i] > 0);
        end
        return s;
    endfunction

    task automatic model_reset();
        for (int i = 0; i < DIM; i++) begin
            m_cnt[i] = 0;
        end
        for (int k = 0; k < NUM_CORES; k++) begin
            m_bound[k] = '0;
        end
        m_store        = '0;
        m_stream_d     = '0;
        m_stream_valid = 1'b0;
    endtask

    // one clock edge of the model, using the inputs driven this cycle
    task automatic model_step();
        int total;
        // read sees the counts from before this edge
        m_stream_valid = read_v;
        if (read_v) begin
            m_stream_d = model_sign();
        end
        // votes from last cycle's bound vectors
        for (int i = 0; i < DIM; i++) begin
            if (clear) begin
                m_cnt[i] = 0;
            end else begin
                total = m_cnt[i];
                for (int k = 0; k < NUM_CORES; k++) begin
                    if (m_store[k]) begin
                        total += m_bound[k][i] ? 1 : -1;
                    end
                end
                if (total > CNT_MAX) begin
                    total = CNT_MAX;
                end
                if (total < CNT_MIN) begin
                    total = CNT_MIN;
                end
                m_cnt[i] = total;
            end
        end
        // binding stage, core k rotates by k
        for (int k = 0; k < NUM_CORES; k++) begin
            if (sample_valid) begin
                m_bound[k] = rotl(sample_hv[k*DIM +: DIM] ^ key_hv[k*DIM +: DIM], k);
            end
            m_store[k] = sample_valid & core_en[k];
        end
    endtask

    task automatic drive_row(input row_t row);
        sample_valid = ((row.op & OP_SAMPLE) != 3'b000);
        clear        = ((row.op & OP_CLEAR) != 3'b000);
        read_v       = ((row.op & OP_READ) != 3'b000);
        core_en      = row.en;
        if (sample_valid) begin
            for (int k = 0; k < NUM_CORES; k++) begin
                case (row.pat)
                    PAT_ONES:  sample_hv[k*DIM +: DIM] = ~key_hv[k*DIM +: DIM];
                    PAT_ZEROS: sample_hv[k*DIM +: DIM] = key_hv[k*DIM +: DIM];
                    default:   sample_hv[k*DIM +: DIM] = {$random(seed), $random(seed)};
                endcase
            end
        end
    endtask

    task automatic check_vec(input string name, input logic [DIM-1:0] got,
                             input logic [DIM-1:0] exp);
        n_checks++;
        if (got !== exp) begin
            $display("MISMATCH %s: expected %h, got %h at cycle %0d", name, exp, got, cycles);
            n_errors++;
            test_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            $display("MISMATCH %s: expected %h, got %h at cycle %0d", name, exp, got, cycles);
            n_errors++;
            test_errors++;
        end
    endtask

    // outputs reflect the last edge, so does the model
    task automatic check_outputs();
        check_bit("stream_valid", stream_valid, m_stream_valid);
        if (m_stream_valid) begin
            check_vec("stream_d", stream_d, m_stream_d);
        end
        check_vec("sign_bit", sign_bit, model_sign());
    endtask

    task automatic report_test(input logic [3:0] id);
        if (test_errors == 0) begin
            $display("test %0d %s: pass", id, test_name(id));
        end else begin
            $display("test %0d %s: FAIL, %0d errors", id, test_name(id), test_errors);
        end
    endtask

    // main sequence
    initial begin
        seed         = 32'h436e_61dd;
        arst_n       = 1'b0;
        sample_valid = 1'b0;
        sample_hv    = '0;
        key_hv       = '0;
        core_en      = '0;
        clear        = 1'b0;
        read_v       = 1'b0;
        model_reset();
        build_table();
        limit = 2 * table_cycles() + 200;

        // one fixed random key per core
        for (int k = 0; k < NUM_CORES; k++) begin
            key_hv[k*DIM +: DIM] = {$random(seed), $random(seed)};
        end

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        arst_n = 1'b1;

        cur_test = rows[0].test_id;
        for (int r = 0; r < rows.size(); r++) begin
            if (rows[r].test_id != cur_test) begin
                report_test(cur_test);
                cur_test    = rows[r].test_id;
                test_errors = 0;
            end
            for (int n = 0; n < int'(rows[r].repeat_n); n++) begin
                drive_row(rows[r]);
                @(negedge clk);
                check_outputs();
                @(posedge clk);
                model_step();
                #DRIVE_DELAY;
            end
        end

        // last edge still needs a look
        sample_valid = 1'b0;
        clear        = 1'b0;
        read_v       = 1'b0;
        @(negedge clk);
        check_outputs();
        report_test(cur_test);

        $display("%0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // watchdog, limit derived from the table length
    initial begin
        wait (limit > 0);
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", limit);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire
